// ==== flist.f ====
hdl/fpgaCtrlPkg.sv
hdl/axiLiteRegPort.sv
hdl/fpgaRegBank.sv
hdl/periphRouteFilter.sv
hdl/ledStatusDriver.sv
hdl/fpgaCtrlTop.sv
test/tbClockGen.sv
test/fpgaCtrlTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS = --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
TOP = fpgaCtrlTb
FLIST = flist.f
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# A failing run ends in $$fatal, so the binary exits non-zero
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/fpgaCtrlTb.sv ====
`timescale 1ns/100ps

module fpgaCtrlTb;
	import fpgaCtrlPkg::*;

	localparam int CLK_PERIOD_NS = 40;
	localparam int NUM_PKTS = 32;
	localparam int NUM_LED_STEPS = 16;
	// Bus transactions plus packets plus LED steps
	localparam int NUM_ITEMS = 40 + 2 * NUM_PKTS + 2 * NUM_LED_STEPS;
	localparam int ITEM_CYCLES = 20;
	localparam int TIMEOUT_NS = NUM_ITEMS * ITEM_CYCLES * CLK_PERIOD_NS;
	localparam logic [31:0] VERSION_WORD = 32'h0301_0042;
	localparam logic [5:0] FLAGS_WORD = 6'b100101;

	logic CLK_IN;
	logic RESET_IN;
	logic awValid;
	logic awReady;
	logic [REGA_BITS+1:0] awAddr;
	logic wValid;
	logic wReady;
	logic [REGD_BITS-1:0] wData;
	logic bValid;
	logic bReady;
	logic [1:0] bResp;
	logic arValid;
	logic arReady;
	logic [REGA_BITS+1:0] arAddr;
	logic rValid;
	logic rReady;
	logic [REGD_BITS-1:0] rData;
	logic [1:0] rResp;
	logic [REGD_BITS-1:0] version;
	logic [5:0] flags;
	logic [NUM_LINKS-1:0] linkUp;
	mcPacket_t inPkt;
	logic inValid;
	logic inReady;
	mcPacket_t periphPkt;
	logic periphValid;
	logic periphReady;
	mcPacket_t ringPkt;
	logic ringValid;
	logic ringReady;
	logic [NUM_LINKS-1:0] ledRed;
	logic [NUM_LINKS-1:0] ledGreen;
	logic [REGD_BITS-1:0] scrambleIdle;
	logic [REGD_BITS-1:0] linkEnable;

	// Expected register contents, kept by the testbench
	logic [31:0] keyReg = PKEY_RESET;
	logic [31:0] maskReg = PMSK_RESET;
	logic [31:0] scrmReg = SCRM_RESET;
	logic [31:0] slenReg = SLEN_RESET;
	logic [7:0] ledoReg = LEDO_RESET;
	logic [31:0] lcgState = 32'd34356;

	tbClockGen u_tbClockGen (.CLK_IN(CLK_IN), .RESET_IN(RESET_IN));

	fpgaCtrlTop u_fpgaCtrlTop (.*);

	// Numerical Recipes constants
	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic checkValue(input logic [64:0] actual, input logic [64:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual,
				expected);
			abortRun("Check failed");
		end
	endtask

	task automatic axiWrite(input logic [REGA_BITS-1:0] index, input logic [31:0] data,
		output logic [1:0] resp);
		logic awTaken;
		logic wTaken;
		@(negedge CLK_IN);
		awAddr = {index, 2'b00};
		wData = data;
		awValid = 1'b1;
		wValid = 1'b1;
		bReady = 1'b1;
		// Each channel drops valid after its own handshake
		while (awValid || wValid)
		begin
			awTaken = awValid && awReady;
			wTaken = wValid && wReady;
			@(negedge CLK_IN);
			if (awTaken)
				awValid = 1'b0;
			if (wTaken)
				wValid = 1'b0;
		end
		while (!bValid)
			@(negedge CLK_IN);
		resp = bResp;
		@(negedge CLK_IN);
		bReady = 1'b0;
	endtask

	task automatic axiRead(input logic [REGA_BITS-1:0] index, output logic [31:0] data,
		output logic [1:0] resp);
		logic arTaken;
		@(negedge CLK_IN);
		arAddr = {index, 2'b00};
		arValid = 1'b1;
		rReady = 1'b1;
		while (arValid)
		begin
			arTaken = arReady;
			@(negedge CLK_IN);
			if (arTaken)
				arValid = 1'b0;
		end
		while (!rValid)
			@(negedge CLK_IN);
		data = rData;
		resp = rResp;
		@(negedge CLK_IN);
		rReady = 1'b0;
	endtask

	task automatic writeExpect(input logic [REGA_BITS-1:0] index, input logic [31:0] data,
		input logic [1:0] expResp, input string what);
		logic [1:0] resp;
		axiWrite(index, data, resp);
		checkValue(65'(resp), 65'(expResp), what);
	endtask

	task automatic readExpect(input logic [REGA_BITS-1:0] index, input logic [31:0] expData,
		input logic [1:0] expResp, input string what);
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(index, data, resp);
		checkValue(65'(resp), 65'(expResp), {what, " response"});
		checkValue(65'(data), 65'(expData), {what, " data"});
	endtask

	// Whole register map against the expected copies
	task automatic verifyContents();
		readExpect(VERS_REG, VERSION_WORD, RESP_OKAY, "version");
		readExpect(FLAG_REG, 32'(FLAGS_WORD), RESP_OKAY, "flags");
		readExpect(PKEY_REG, keyReg, RESP_OKAY, "periph key");
		readExpect(PMSK_REG, maskReg, RESP_OKAY, "periph mask");
		readExpect(SCRM_REG, scrmReg, RESP_OKAY, "scramble word");
		readExpect(SLEN_REG, slenReg, RESP_OKAY, "link enable");
		// Only the low byte comes back
		readExpect(LEDO_REG, 32'(ledoReg), RESP_OKAY, "LED override");
		checkValue(65'(scrambleIdle), 65'(scrmReg), "scrambleIdle output");
		checkValue(65'(linkEnable), 65'(slenReg), "linkEnable output");
	endtask

	task automatic checkLeds();
		logic [NUM_LINKS-1:0] expRed;
		logic [NUM_LINKS-1:0] expGreen;
		for (int b = 0; b < NUM_LINKS; b++)
		begin
			expRed[b] = 1'b0;
			expGreen[b] = 1'b0;
			// Dim first, then error or link down, else healthy
			if (!ledoReg[NUM_LINKS + b])
			begin
				if (ledoReg[b] || !linkUp[b])
					expRed[b] = 1'b1;
				else
					expGreen[b] = 1'b1;
			end
		end
		checkValue(65'(ledRed), 65'(expRed), "red LEDs");
		checkValue(65'(ledGreen), 65'(expGreen), "green LEDs");
	endtask

	task automatic runPackets(input int count, input bit stalls);
		mcPacket_t pkt;
		mcPacket_t expPeriph[$];
		mcPacket_t expRing[$];
		mcPacket_t heldP;
		mcPacket_t heldR;
		logic stallP;
		logic stallR;
		logic taken;
		logic [31:0] r;
		int sent;
		sent = 0;
		stallP = 1'b0;
		stallR = 1'b0;
		taken = 1'b0;
		heldP = '0;
		heldR = '0;
		while (sent < count || inValid || expPeriph.size() != 0 || expRing.size() != 0)
		begin
			@(negedge CLK_IN);
			r = lcgNext();
			periphReady = !stalls || r[31];
			ringReady = !stalls || r[30];
			if (taken)
				inValid = 1'b0;
			// Input gaps only in the stall run
			if (!inValid && sent < count && (!stalls || r[29]))
			begin
				pkt.key = lcgNext();
				pkt.payload = lcgNext();
				pkt.hasPayload = r[28];
				// Half the keys forced onto the peripheral route
				if (r[27])
					pkt.key = (pkt.key & ~maskReg) | keyReg;
				if ((pkt.key & maskReg) == keyReg)
					expPeriph.push_back(pkt);
				else
					expRing.push_back(pkt);
				inPkt = pkt;
				inValid = 1'b1;
				sent++;
			end
			// Ready paths settle
			#1;
			// Full-rate stream sees no bubbles
			if (!stalls)
				checkValue(65'(inReady), 65'(1'b1), "input ready at full rate");
			if (stallP)
			begin
				checkValue(65'(periphValid), 65'(1'b1), "periph valid lost while stalled");
				checkValue(periphPkt, heldP, "periph packet changed while stalled");
			end
			if (stallR)
			begin
				checkValue(65'(ringValid), 65'(1'b1), "ring valid lost while stalled");
				checkValue(ringPkt, heldR, "ring packet changed while stalled");
			end
			if (periphValid && periphReady)
			begin
				if (expPeriph.size() == 0)
					abortRun("Unexpected packet on the periph stream");
				else
					checkValue(periphPkt, expPeriph.pop_front(), "periph packet");
			end
			if (ringValid && ringReady)
			begin
				if (expRing.size() == 0)
					abortRun("Unexpected packet on the ring stream");
				else
					checkValue(ringPkt, expRing.pop_front(), "ring packet");
			end
			stallP = periphValid && !periphReady;
			stallR = ringValid && !ringReady;
			heldP = periphPkt;
			heldR = ringPkt;
			taken = inValid && inReady;
		end
		// Nothing left behind, nothing sent twice
		@(negedge CLK_IN);
		checkValue(65'({periphValid, ringValid}), 65'(2'b00), "output valid after drain");
	endtask

	task automatic testResetValues();
		checkValue(65'({awReady, wReady, arReady, bValid, rValid, periphValid, ringValid}),
			65'(7'b1110000), "ready/valid after reset");
		checkLeds();
		verifyContents();
	endtask

	task automatic testRegisterAccess();
		logic [31:0] r;
		r = lcgNext();
		writeExpect(PKEY_REG, r, RESP_OKAY, "periph key write");
		keyReg = r;
		r = lcgNext();
		writeExpect(PMSK_REG, r, RESP_OKAY, "periph mask write");
		maskReg = r;
		r = lcgNext();
		writeExpect(SCRM_REG, r, RESP_OKAY, "scramble write");
		scrmReg = r;
		// Output follows as soon as the response is back
		checkValue(65'(scrambleIdle), 65'(scrmReg), "scrambleIdle after write");
		r = lcgNext();
		writeExpect(SLEN_REG, r, RESP_OKAY, "link enable write");
		slenReg = r;
		r = lcgNext();
		writeExpect(LEDO_REG, r, RESP_OKAY, "LED override write");
		ledoReg = r[7:0];
		verifyContents();
	endtask

	task automatic testAccessErrors();
		writeExpect(VERS_REG, lcgNext(), RESP_SLVERR, "write to version");
		writeExpect(FLAG_REG, lcgNext(), RESP_SLVERR, "write to flags");
		writeExpect(14'd7, lcgNext(), RESP_SLVERR, "write to index 7");
		writeExpect(14'h2A5C, lcgNext(), RESP_SLVERR, "write to index 0x2A5C");
		verifyContents();
		readExpect(14'h3FFF, UNMAPPED_DATA, RESP_SLVERR, "unmapped read");
	endtask

	task automatic testPacketSteering();
		// Key must lie inside the mask to be reachable
		maskReg = lcgNext();
		keyReg = lcgNext() & maskReg;
		writeExpect(PMSK_REG, maskReg, RESP_OKAY, "steering mask write");
		writeExpect(PKEY_REG, keyReg, RESP_OKAY, "steering key write");
		runPackets(NUM_PKTS, 1'b0);
	endtask

	task automatic testBackPressure();
		runPackets(NUM_PKTS, 1'b1);
	endtask

	task automatic testLedOverrides();
		logic [31:0] r;
		logic [7:0] ovr;
		for (int step = 0; step < NUM_LED_STEPS; step++)
		begin
			r = lcgNext();
			ovr = r[31:24];
			// Dim only now and then
			if (r[23:22] != 2'b00)
				ovr[7:4] = 4'h0;
			writeExpect(LEDO_REG, 32'(ovr), RESP_OKAY, "LED sweep write");
			ledoReg = ovr;
			@(negedge CLK_IN);
			linkUp = 4'(step);
			@(negedge CLK_IN);
			checkLeds();
		end
	endtask

	// Bounded by the total test length
	initial
	begin
		#(TIMEOUT_NS);
		abortRun("Timeout, the tests did not finish in the expected time");
	end

	initial
	begin
		awValid = 1'b0;
		awAddr = '0;
		wValid = 1'b0;
		wData = '0;
		bReady = 1'b0;
		arValid = 1'b0;
		arAddr = '0;
		rReady = 1'b0;
		version = VERSION_WORD;
		flags = FLAGS_WORD;
		// Links up, so red at reset comes from the forced error bits
		linkUp = '1;
		inPkt = '0;
		inValid = 1'b0;
		periphReady = 1'b0;
		ringReady = 1'b0;
		@(negedge RESET_IN);
		@(negedge CLK_IN);
		testResetValues();
		testRegisterAccess();
		testAccessErrors();
		testPacketSteering();
		testBackPressure();
		testLedOverrides();
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== test/tbClockGen.sv ====
`timescale 1ns/100ps

module tbClockGen
(
	output logic CLK_IN,
	output logic RESET_IN
);
	// 40 ns period
	localparam int HALF_PERIOD_NS = 20;

	initial
	begin
		CLK_IN = 1'b0;
		forever #(HALF_PERIOD_NS) CLK_IN = ~CLK_IN;
	end

	// Two full cycles of reset, released on a falling edge
	initial
	begin
		RESET_IN = 1'b1;
		repeat (2) @(posedge CLK_IN);
		@(negedge CLK_IN);
		RESET_IN = 1'b0;
	end

endmodule

// ==== hdl/fpgaCtrlTop.sv ====
`timescale 1ns/100ps

module fpgaCtrlTop
(
	input logic CLK_IN,
	input logic RESET_IN,
	// AXI4-Lite slave
	input logic awValid,
	output logic awReady,
	input logic [fpgaCtrlPkg::REGA_BITS+1:0] awAddr,
	input logic wValid,
	output logic wReady,
	input logic [fpgaCtrlPkg::REGD_BITS-1:0] wData,
	output logic bValid,
	input logic bReady,
	output logic [1:0] bResp,
	input logic arValid,
	output logic arReady,
	input logic [fpgaCtrlPkg::REGA_BITS+1:0] arAddr,
	output logic rValid,
	input logic rReady,
	output logic [fpgaCtrlPkg::REGD_BITS-1:0] rData,
	output logic [1:0] rResp,
	// Readback-only inputs
	input logic [fpgaCtrlPkg::REGD_BITS-1:0] version,
	input logic [5:0] flags,
	// Link state for the LEDs
	input logic [fpgaCtrlPkg::NUM_LINKS-1:0] linkUp,
	// Multicast streams
	input fpgaCtrlPkg::mcPacket_t inPkt,
	input logic inValid,
	output logic inReady,
	output fpgaCtrlPkg::mcPacket_t periphPkt,
	output logic periphValid,
	input logic periphReady,
	output fpgaCtrlPkg::mcPacket_t ringPkt,
	output logic ringValid,
	input logic ringReady,
	// Status LEDs
	output logic [fpgaCtrlPkg::NUM_LINKS-1:0] ledRed,
	output logic [fpgaCtrlPkg::NUM_LINKS-1:0] ledGreen,
	// Words for the link logic outside this block
	output logic [fpgaCtrlPkg::REGD_BITS-1:0] scrambleIdle,
	output logic [fpgaCtrlPkg::REGD_BITS-1:0] linkEnable
);
	import fpgaCtrlPkg::*;

	regAccess_t access;
	regResponse_t response;
	ctrlRegs_t regs;

	// Bus to register pulses
	axiLiteRegPort u_axiLiteRegPort (.*);

	// Register storage
	fpgaRegBank u_fpgaRegBank (.*);

	// Peripheral steering
	periphRouteFilter u_periphRouteFilter (.*);

	ledStatusDriver u_ledStatusDriver
	(
		.CLK_IN(CLK_IN),
		.RESET_IN(RESET_IN),
		.linkUp(linkUp),
		.override(regs.ledOverride),
		.ledRed(ledRed),
		.ledGreen(ledGreen)
	);

	// Stored only, used elsewhere
	assign scrambleIdle = regs.scrambleIdle;
	assign linkEnable = regs.linkEnable;

endmodule

// ==== hdl/ledStatusDriver.sv ====
`timescale 1ns/100ps

module ledStatusDriver
(
	input logic CLK_IN,
	input logic RESET_IN,
	// Per-link state, B2B0/B2B1/PERIPH/RING
	input logic [fpgaCtrlPkg::NUM_LINKS-1:0] linkUp,
	// Software override byte
	input fpgaCtrlPkg::ledOverride_t override,
	// LED drive, one bit per link
	output logic [fpgaCtrlPkg::NUM_LINKS-1:0] ledRed,
	output logic [fpgaCtrlPkg::NUM_LINKS-1:0] ledGreen
);
	import fpgaCtrlPkg::*;

	logic [NUM_LINKS-1:0] redNext;
	logic [NUM_LINKS-1:0] greenNext;

	// Dim beats everything
	// Forced error or link down shows red
	assign redNext = ~override.dim & (override.forceError | ~linkUp);
	// Green only for a healthy, unforced link
	assign greenNext = ~override.dim & ~override.forceError & linkUp;

	// Registered outputs, one cycle behind the inputs
	always_ff @(posedge CLK_IN, posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			// Matches the force-error reset of the bank
			ledRed <= '1;
			ledGreen <= '0;
		end
		else
		begin
			ledRed <= redNext;
			ledGreen <= greenNext;
		end
	end

endmodule

// ==== hdl/periphRouteFilter.sv ====
`timescale 1ns/100ps

module periphRouteFilter
(
	input logic CLK_IN,
	input logic RESET_IN,
	// Incoming multicast stream
	input fpgaCtrlPkg::mcPacket_t inPkt,
	input logic inValid,
	output logic inReady,
	// Packets for the peripheral
	output fpgaCtrlPkg::mcPacket_t periphPkt,
	output logic periphValid,
	input logic periphReady,
	// Everything else goes round the ring
	output fpgaCtrlPkg::mcPacket_t ringPkt,
	output logic ringValid,
	input logic ringReady,
	// Key and mask from the bank
	input fpgaCtrlPkg::ctrlRegs_t regs
);
	import fpgaCtrlPkg::*;

	mcPacket_t heldPkt;
	logic heldValid;
	// Destination chosen at load time
	logic heldPeriph;
	logic inMatch;
	logic heldLeaves;

	assign inMatch = ((inPkt.key & regs.periphMask) == regs.periphKey);

	// Stage frees up when its packet is taken
	assign heldLeaves = heldValid && (heldPeriph ? periphReady : ringReady);
	assign inReady = !heldValid || heldLeaves;

	// Occupancy
	always_ff @(posedge CLK_IN, posedge RESET_IN)
	begin
		if (RESET_IN)
			heldValid <= 1'b0;
		else if (inReady)
			heldValid <= inValid;
	end

	// Packet and route
	always_ff @(posedge CLK_IN)
	begin
		if (inValid && inReady)
		begin
			heldPkt <= inPkt;
			heldPeriph <= inMatch;
		end
	end

	// Same packet on both, valid on one
	assign periphPkt = heldPkt;
	assign ringPkt = heldPkt;
	assign periphValid = heldValid && heldPeriph;
	assign ringValid = heldValid && !heldPeriph;

	assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		!(periphValid && ringValid));
	// Stalled packet holds even if key or mask are rewritten
	assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		periphValid && !periphReady |=> periphValid && $stable(periphPkt));
	assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		ringValid && !ringReady |=> ringValid && $stable(ringPkt));

endmodule

// ==== hdl/fpgaRegBank.sv ====
`timescale 1ns/100ps

module fpgaRegBank
(
	input logic CLK_IN,
	input logic RESET_IN,
	// Access from the bus port
	input fpgaCtrlPkg::regAccess_t access,
	output fpgaCtrlPkg::regResponse_t response,
	// Design version word
	input logic [fpgaCtrlPkg::REGD_BITS-1:0] version,
	// Compile flags, chipscope/periph/ring/north-south/FPGA id
	input logic [5:0] flags,
	// Stored words to the consumers
	output fpgaCtrlPkg::ctrlRegs_t regs
);
	import fpgaCtrlPkg::*;

	// Writable words
	always_ff @(posedge CLK_IN, posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			regs.periphKey <= PKEY_RESET;
			regs.periphMask <= PMSK_RESET;
			regs.scrambleIdle <= SCRM_RESET;
			regs.linkEnable <= SLEN_RESET;
			regs.ledOverride <= LEDO_RESET;
		end
		else if (access.write)
		begin
			case (access.index)
				PKEY_REG: regs.periphKey <= access.wdata;
				PMSK_REG: regs.periphMask <= access.wdata;
				SCRM_REG: regs.scrambleIdle <= access.wdata;
				SLEN_REG: regs.linkEnable <= access.wdata;
				// Only the override byte is kept
				LEDO_REG: regs.ledOverride <= ledOverride_t'(access.wdata[7:0]);
				default: ;
			endcase
		end
	end

	// Read mux and error flag
	always_comb
	begin
		response.rdata = UNMAPPED_DATA;
		response.error = 1'b0;
		case (access.index)
			// Read-only, a write here is refused
			VERS_REG:
			begin
				response.rdata = version;
				response.error = access.write;
			end
			FLAG_REG:
			begin
				response.rdata = REGD_BITS'(flags);
				response.error = access.write;
			end
			PKEY_REG: response.rdata = regs.periphKey;
			PMSK_REG: response.rdata = regs.periphMask;
			SCRM_REG: response.rdata = regs.scrambleIdle;
			SLEN_REG: response.rdata = regs.linkEnable;
			LEDO_REG: response.rdata = REGD_BITS'(regs.ledOverride);
			// Nothing mapped, either direction fails
			default:
			begin
				response.rdata = UNMAPPED_DATA;
				response.error = access.write || access.read;
			end
		endcase
	end

	// Port must present a clean index with every pulse
	assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		(access.write || access.read) |-> !$isunknown(access.index));

endmodule

// ==== hdl/axiLiteRegPort.sv ====
`timescale 1ns/100ps

module axiLiteRegPort
(
	input logic CLK_IN,
	input logic RESET_IN,
	// Write address
	input logic awValid,
	output logic awReady,
	input logic [fpgaCtrlPkg::REGA_BITS+1:0] awAddr,
	// Write data
	input logic wValid,
	output logic wReady,
	input logic [fpgaCtrlPkg::REGD_BITS-1:0] wData,
	// Write response
	output logic bValid,
	input logic bReady,
	output logic [1:0] bResp,
	// Read address
	input logic arValid,
	output logic arReady,
	input logic [fpgaCtrlPkg::REGA_BITS+1:0] arAddr,
	// Read data
	output logic rValid,
	input logic rReady,
	output logic [fpgaCtrlPkg::REGD_BITS-1:0] rData,
	output logic [1:0] rResp,
	// Register bank side
	output fpgaCtrlPkg::regAccess_t access,
	input fpgaCtrlPkg::regResponse_t response
);
	import fpgaCtrlPkg::*;

	typedef enum logic [2:0] {ST_IDLE, ST_WRITE, ST_READ, ST_BRESP, ST_RRESP} portState_t;

	portState_t state;
	// Address/data already taken but not yet used
	logic awHeld;
	logic wHeld;
	logic arHeld;
	logic [REGA_BITS-1:0] wrIndex;
	logic [REGD_BITS-1:0] wrData;
	logic [REGA_BITS-1:0] rdIndex;
	logic awFire;
	logic wFire;
	logic arFire;
	logic wrPending;
	logic rdPending;

	// Channels open only while idle, one beat each
	assign awReady = (state == ST_IDLE) && !awHeld;
	assign wReady = (state == ST_IDLE) && !wHeld;
	assign arReady = (state == ST_IDLE) && !arHeld;

	assign awFire = awValid && awReady;
	assign wFire = wValid && wReady;
	assign arFire = arValid && arReady;

	// Includes beats arriving this very edge
	assign wrPending = (awHeld || awFire) && (wHeld || wFire);
	assign rdPending = arHeld || arFire;

	// Transaction sequencing
	always_ff @(posedge CLK_IN, posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			state <= ST_IDLE;
			awHeld <= 1'b0;
			wHeld <= 1'b0;
			arHeld <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					awHeld <= awHeld || awFire;
					wHeld <= wHeld || wFire;
					arHeld <= arHeld || arFire;
					// Write wins over a read pending alongside
					if (wrPending)
					begin
						awHeld <= 1'b0;
						wHeld <= 1'b0;
						state <= ST_WRITE;
					end
					else if (rdPending)
					begin
						arHeld <= 1'b0;
						state <= ST_READ;
					end
				end
				ST_WRITE: state <= ST_BRESP;
				ST_READ: state <= ST_RRESP;
				ST_BRESP: if (bReady) state <= ST_IDLE;
				ST_RRESP: if (rReady) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Captured address, data and responses
	always_ff @(posedge CLK_IN)
	begin
		if (awFire)
			wrIndex <= awAddr[REGA_BITS+1:2];
		if (wFire)
			wrData <= wData;
		if (arFire)
			rdIndex <= arAddr[REGA_BITS+1:2];
		if (state == ST_WRITE)
			bResp <= response.error ? RESP_SLVERR : RESP_OKAY;
		if (state == ST_READ)
		begin
			rData <= response.rdata;
			rResp <= response.error ? RESP_SLVERR : RESP_OKAY;
		end
	end

	assign bValid = (state == ST_BRESP);
	assign rValid = (state == ST_RRESP);

	// One-cycle pulse to the bank
	always_comb
	begin
		access.write = (state == ST_WRITE);
		access.read = (state == ST_READ);
		access.index = (state == ST_WRITE) ? wrIndex : rdIndex;
		access.wdata = wrData;
	end

	// Held responses stay put until taken
	assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		bValid && !bReady |=> bValid && $stable(bResp));
	assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp));
	// Bank never sees both directions at once
	assert property (@(posedge CLK_IN) disable iff (RESET_IN)
		!(access.write && access.read));

endmodule

// ==== hdl/fpgaCtrlPkg.sv ====
package fpgaCtrlPkg;

	// Register word index and data widths
	localparam int REGA_BITS = 14;
	localparam int REGD_BITS = 32;

	// Links in bit order B2B0, B2B1, PERIPH, RING
	localparam int NUM_LINKS = 4;

	// Register map, word indices
	localparam logic [REGA_BITS-1:0] VERS_REG = 14'd0;
	localparam logic [REGA_BITS-1:0] FLAG_REG = 14'd1;
	localparam logic [REGA_BITS-1:0] PKEY_REG = 14'd2;
	localparam logic [REGA_BITS-1:0] PMSK_REG = 14'd3;
	localparam logic [REGA_BITS-1:0] SCRM_REG = 14'd4;
	localparam logic [REGA_BITS-1:0] SLEN_REG = 14'd5;
	localparam logic [REGA_BITS-1:0] LEDO_REG = 14'd6;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// LED override byte, dim in the high nibble
	typedef struct packed {
		logic [NUM_LINKS-1:0] dim;
		logic [NUM_LINKS-1:0] forceError;
	} ledOverride_t;

	// Reset values of the writable words
	localparam logic [REGD_BITS-1:0] PKEY_RESET = '1;
	localparam logic [REGD_BITS-1:0] PMSK_RESET = '0;
	localparam logic [REGD_BITS-1:0] SCRM_RESET = '1;
	localparam logic [REGD_BITS-1:0] SLEN_RESET = '0;
	// All links forced to error until software says otherwise
	localparam ledOverride_t LEDO_RESET = '{dim: '0, forceError: '1};

	// Read data of an unmapped index
	localparam logic [REGD_BITS-1:0] UNMAPPED_DATA = '1;

	// Single register access, port to bank
	typedef struct packed {
		logic write;
		logic read;
		logic [REGA_BITS-1:0] index;
		logic [REGD_BITS-1:0] wdata;
	} regAccess_t;

	// Bank answer, same cycle as the access
	typedef struct packed {
		logic [REGD_BITS-1:0] rdata;
		logic error;
	} regResponse_t;

	// Stored control words
	typedef struct packed {
		logic [REGD_BITS-1:0] periphKey;
		logic [REGD_BITS-1:0] periphMask;
		logic [REGD_BITS-1:0] scrambleIdle;
		logic [REGD_BITS-1:0] linkEnable;
		ledOverride_t ledOverride;
	} ctrlRegs_t;

	// Multicast packet
	typedef struct packed {
		logic [31:0] key;
		logic [31:0] payload;
		logic hasPayload;
	} mcPacket_t;

endpackage
